// File: seq_pkg.sv
package seq_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int idx_w      = 2;  // slot index and slot counter, four slots
    localparam int addr_w     = 32; // source and destination address
    localparam int size_w     = 26; // transfer size
    localparam int stat_w     = 2;  // per slot status code
    localparam int prof_w     = 32; // per slot profile count
    localparam int init_tasks = 6;  // dma setup steps, addr and size per channel

    ////////////////////////////////////////////////////////////
    // slot descriptor
    ////////////////////////////////////////////////////////////

    // one entry of the table, msb field first
    typedef struct packed {
        logic [addr_w-1:0] src_addr;
        logic [size_w-1:0] src_size;
        logic [addr_w-1:0] dst_addr;
        logic [size_w-1:0] dst_size;
        logic [stat_w-1:0] status;
        logic [prof_w-1:0] profile;
    } slot_desc_t;

    // per field write select, same order as slot_desc_t
    typedef struct packed {
        logic src_addr;
        logic src_size;
        logic dst_addr;
        logic dst_size;
        logic status;
        logic profile;
    } field_sel_t;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    // sequencer status, also read back by the host
    typedef enum logic [3:0] {
        st_shutdown       = 4'd0, // idle, host owns the table
        st_reprog         = 4'd1, // one cycle reprogram pulse
        st_w4_slave_reset = 4'd2, // wait for nslave_reset low
        st_w4_slave_op    = 4'd3, // wait for nslave_reset high again
        st_initializing   = 4'd4, // dma setup chain running
        st_triggering     = 4'd5, // single cycle
        st_wait4fin       = 4'd6  // wait for exec_fin
    } seq_state_e;

    // host control word
    typedef enum logic [3:0] {
        cmd_clear    = 4'd0, // back to shutdown and zero counters
        cmd_shutdown = 4'd1, // stop but keep counter
        cmd_start    = 4'd2  // only taken from shutdown
    } ctrl_cmd_e;

endpackage

// File: slot_table.sv
module slot_table (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [seq_pkg::idx_w-1:0] index,        // shared read and write index
    input  seq_pkg::slot_desc_t       wr_desc,      // host write data
    input  seq_pkg::field_sel_t       wr_en,        // accepted field writes
    input  logic                      profile_bump, // count one reprogram of this slot
    output seq_pkg::slot_desc_t       rd_desc
);

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    seq_pkg::slot_desc_t slots [2**seq_pkg::idx_w]; // one descriptor per slot

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 2**seq_pkg::idx_w; i++) begin
                slots[i] <= '0;
            end
        end else begin
            // each field has its own enable
            if (wr_en.src_addr) begin
                slots[index].src_addr <= wr_desc.src_addr;
            end
            if (wr_en.src_size) begin
                slots[index].src_size <= wr_desc.src_size;
            end
            if (wr_en.dst_addr) begin
                slots[index].dst_addr <= wr_desc.dst_addr;
            end
            if (wr_en.dst_size) begin
                slots[index].dst_size <= wr_desc.dst_size;
            end
            if (wr_en.status) begin
                slots[index].status <= wr_desc.status;
            end
            // the sequencer bump wins over a host profile write
            if (profile_bump) begin
                slots[index].profile <= slots[index].profile + 1'b1;
            end else if (wr_en.profile) begin
                slots[index].profile <= wr_desc.profile;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    // combinational, same index as the write side
    assign rd_desc = slots[index];

endmodule

// File: host_access.sv
module host_access (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      idle,          // sequencer in shutdown
    input  logic [seq_pkg::idx_w-1:0] slot_cnt,      // current slot of the run
    input  logic [seq_pkg::idx_w-1:0] wr_index,
    input  logic [seq_pkg::idx_w-1:0] rd_index,
    input  seq_pkg::field_sel_t       wr_sel,        // fields the host wants to write
    input  logic                      rd_req,
    input  logic                      end_cnt_valid,
    input  logic [seq_pkg::idx_w-1:0] end_cnt_in,
    output seq_pkg::field_sel_t       wr_ack,        // fields that really get written
    output logic                      rd_ready,
    output logic [seq_pkg::idx_w-1:0] tbl_index,     // index into the slot table
    output logic [seq_pkg::idx_w-1:0] end_cnt        // last slot of a run
);

    logic host_wr; // any field select raised this cycle

    ////////////////////////////////////////////////////////////
    // host slot write and read gating
    ////////////////////////////////////////////////////////////

    assign host_wr = |wr_sel;

    // writes only land while shut down
    // no retry on the host side, a low ack means dropped
    assign wr_ack = idle ? wr_sel : '0;

    assign rd_ready = rd_req & idle; // same cycle as the request

    ////////////////////////////////////////////////////////////
    // table index select
    ////////////////////////////////////////////////////////////

    // the table has one port index
    // a running sequencer always owns it
    always_comb begin
        if (!idle) begin
            tbl_index = slot_cnt;
        end else if (host_wr) begin
            tbl_index = wr_index; // write in progress
        end else begin
            tbl_index = rd_index;
        end
    end

    ////////////////////////////////////////////////////////////
    // end count register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            end_cnt <= '0;
        end else if (idle && end_cnt_valid) begin
            end_cnt <= end_cnt_in; // ignored while a run is active
        end
    end

endmodule

// File: seq_fsm.sv
module seq_fsm (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ctrl_valid,   // one cycle command strobe
    input  seq_pkg::ctrl_cmd_e            ctrl_cmd,
    input  logic [seq_pkg::idx_w-1:0]     end_cnt,      // last slot to run
    input  logic                          nslave_reset, // slave reset, active low
    input  logic [seq_pkg::init_tasks-1:0] init_fin,    // slave ack per setup task
    input  logic                          exec_fin,     // slave run done
    output seq_pkg::seq_state_e           state,
    output logic [seq_pkg::idx_w-1:0]     slot_cnt,
    output logic                          idle,
    output logic                          slave_reprog,
    output logic [seq_pkg::init_tasks-1:0] init_task    // one hot setup request
);

    ////////////////////////////////////////////////////////////
    // decoded outputs
    ////////////////////////////////////////////////////////////

    assign idle         = (state == seq_pkg::st_shutdown);
    assign slave_reprog = (state == seq_pkg::st_reprog); // exactly one cycle

    ////////////////////////////////////////////////////////////
    // control state, slot counter, setup chain
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state     <= seq_pkg::st_shutdown;
            slot_cnt  <= '0;
            init_task <= '0;
        end else if (ctrl_valid) begin
            // host command overrides the sequence
            case (ctrl_cmd)
                seq_pkg::cmd_clear: begin
                    state     <= seq_pkg::st_shutdown;
                    slot_cnt  <= '0;
                    init_task <= '0;
                end
                seq_pkg::cmd_shutdown: begin
                    state <= seq_pkg::st_shutdown; // counter and chain kept
                end
                seq_pkg::cmd_start: begin
                    if (state == seq_pkg::st_shutdown) begin
                        state    <= seq_pkg::st_reprog;
                        slot_cnt <= '0; // every run starts at slot 0
                    end
                end
                default: begin
                    // unknown code, nothing happens
                end
            endcase
        end else begin
            case (state)
                seq_pkg::st_shutdown: begin
                    // wait for cmd_start
                end
                seq_pkg::st_reprog: begin
                    // profile bump happens in this cycle
                    state <= seq_pkg::st_w4_slave_reset;
                end
                seq_pkg::st_w4_slave_reset: begin
                    if (!nslave_reset) begin
                        state <= seq_pkg::st_w4_slave_op; // slave went into reset
                    end
                end
                seq_pkg::st_w4_slave_op: begin
                    if (nslave_reset) begin
                        state     <= seq_pkg::st_initializing;
                        init_task <= 1; // first setup task
                    end
                end
                seq_pkg::st_initializing: begin
                    if (init_fin[seq_pkg::init_tasks-1]) begin
                        // last task acked, chain done
                        state     <= seq_pkg::st_triggering;
                        init_task <= '0;
                    end else if (|init_fin) begin
                        init_task <= init_task << 1; // next task
                    end
                end
                seq_pkg::st_triggering: begin
                    state <= seq_pkg::st_wait4fin;
                end
                seq_pkg::st_wait4fin: begin
                    if (exec_fin) begin
                        if (slot_cnt < end_cnt) begin
                            slot_cnt <= slot_cnt + 1'b1;
                            state    <= seq_pkg::st_reprog; // next slot
                        end else begin
                            // run complete
                            slot_cnt <= '0;
                            state    <= seq_pkg::st_shutdown;
                        end
                    end
                end
                default: begin
                    state <= seq_pkg::st_shutdown; // unused code, recover
                end
            endcase
        end
    end

endmodule

// File: magic_seq_core.sv
module magic_seq_core (
    input  logic                           clk,
    input  logic                           reset,
    // host slot write
    input  logic [seq_pkg::idx_w-1:0]      wr_index,
    input  seq_pkg::slot_desc_t            wr_desc,
    input  seq_pkg::field_sel_t            wr_sel,
    output seq_pkg::field_sel_t            wr_ack,
    // host slot read
    input  logic                           rd_req,
    input  logic [seq_pkg::idx_w-1:0]      rd_index,
    output logic                           rd_ready,
    output seq_pkg::slot_desc_t            rd_desc,
    // control and end count
    input  logic                           ctrl_valid,
    input  seq_pkg::ctrl_cmd_e             ctrl_cmd,
    input  logic                           end_cnt_valid,
    input  logic [seq_pkg::idx_w-1:0]      end_cnt_in,
    output logic [seq_pkg::idx_w-1:0]      end_cnt,
    // status
    output seq_pkg::seq_state_e            state,
    output logic [seq_pkg::idx_w-1:0]      slot_cnt,
    // slave side
    input  logic                           nslave_reset,
    input  logic [seq_pkg::init_tasks-1:0] init_fin,
    input  logic                           exec_fin,
    output logic                           slave_reprog,
    output logic [seq_pkg::init_tasks-1:0] init_task,
    output seq_pkg::slot_desc_t            slave_desc
);

    logic                      idle;      // fsm in shutdown
    logic [seq_pkg::idx_w-1:0] tbl_index; // host index or slot counter

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////

    seq_fsm fsm0 (
        .clk          (clk),
        .reset        (reset),
        .ctrl_valid   (ctrl_valid),
        .ctrl_cmd     (ctrl_cmd),
        .end_cnt      (end_cnt),
        .nslave_reset (nslave_reset),
        .init_fin     (init_fin),
        .exec_fin     (exec_fin),
        .state        (state),
        .slot_cnt     (slot_cnt),
        .idle         (idle),
        .slave_reprog (slave_reprog),
        .init_task    (init_task)
    );

    ////////////////////////////////////////////////////////////
    // host port
    ////////////////////////////////////////////////////////////

    host_access host0 (
        .clk           (clk),
        .reset         (reset),
        .idle          (idle),
        .slot_cnt      (slot_cnt),
        .wr_index      (wr_index),
        .rd_index      (rd_index),
        .wr_sel        (wr_sel),
        .rd_req        (rd_req),
        .end_cnt_valid (end_cnt_valid),
        .end_cnt_in    (end_cnt_in),
        .wr_ack        (wr_ack),
        .rd_ready      (rd_ready),
        .tbl_index     (tbl_index),
        .end_cnt       (end_cnt)
    );

    ////////////////////////////////////////////////////////////
    // slot table
    ////////////////////////////////////////////////////////////

    // the reprogram pulse doubles as the profile bump
    slot_table table0 (
        .clk          (clk),
        .reset        (reset),
        .index        (tbl_index),
        .wr_desc      (wr_desc),
        .wr_en        (wr_ack),
        .profile_bump (slave_reprog),
        .rd_desc      (rd_desc)
    );

    assign slave_desc = rd_desc; // slave sees the current slot

endmodule

// File: magic_seq_core_sva.sv
module seq_fsm_sva (
    input logic                           clk,
    input logic                           reset,
    input logic                           ctrl_valid,
    input seq_pkg::ctrl_cmd_e             ctrl_cmd,
    input seq_pkg::seq_state_e            state,
    input logic                           slave_reprog,
    input logic [seq_pkg::init_tasks-1:0] init_task
);

    int fail_cnt = 0; // failed assertions, summed into the testbench total

    // reprogram request is a single cycle pulse
    reprog_single: assert property (@(posedge clk) disable iff (!reset)
        slave_reprog |=> !slave_reprog)
        else begin
            $error("slave_reprog high for more than one cycle");
            fail_cnt++;
        end

    // setup chain never has two tasks pending
    task_onehot: assert property (@(posedge clk) disable iff (!reset)
        $onehot0(init_task))
        else begin
            $error("init_task is neither zero nor one hot");
            fail_cnt++;
        end

    clear_to_shutdown: assert property (@(posedge clk) disable iff (!reset)
        ctrl_valid && ctrl_cmd == seq_pkg::cmd_clear |=> state == seq_pkg::st_shutdown)
        else begin
            $error("state not shutdown one cycle after cmd_clear"); // clear beats fsm
            fail_cnt++;
        end

endmodule

bind seq_fsm seq_fsm_sva sva0 (
    .clk          (clk),
    .reset        (reset),
    .ctrl_valid   (ctrl_valid),
    .ctrl_cmd     (ctrl_cmd),
    .state        (state),
    .slave_reprog (slave_reprog),
    .init_task    (init_task)
);

// File: tb_magic_seq_core.sv
module tb_magic_seq_core;

    localparam int wait_limit = 200; // cycles before any wait gives up

    logic                           clk;
    logic                           reset;
    logic [seq_pkg::idx_w-1:0]      wr_index;
    seq_pkg::slot_desc_t            wr_desc;
    seq_pkg::field_sel_t            wr_sel;
    seq_pkg::field_sel_t            wr_ack;
    logic                           rd_req;
    logic [seq_pkg::idx_w-1:0]      rd_index;
    logic                           rd_ready;
    seq_pkg::slot_desc_t            rd_desc;
    logic                           ctrl_valid;
    seq_pkg::ctrl_cmd_e             ctrl_cmd;
    logic                           end_cnt_valid;
    logic [seq_pkg::idx_w-1:0]      end_cnt_in;
    logic [seq_pkg::idx_w-1:0]      end_cnt;
    seq_pkg::seq_state_e            state;
    logic [seq_pkg::idx_w-1:0]      slot_cnt;
    logic                           nslave_reset;
    logic [seq_pkg::init_tasks-1:0] init_fin;
    logic                           exec_fin;
    logic                           slave_reprog;
    logic [seq_pkg::init_tasks-1:0] init_task;
    seq_pkg::slot_desc_t            slave_desc;

    seq_pkg::slot_desc_t       desc_mem [4];       // descriptors from the stimulus file
    logic [31:0]               prof_file [3][4];   // expected profiles after load and each run
    logic [seq_pkg::idx_w-1:0] end_val;
    int                        abort_slot;
    int                        model_prof [4];     // reprogram count seen per slot
    int                        errs [1:6];
    string                     tname [1:6];
    logic [31:0]               seed;

    magic_seq_core dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // period 20
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int rand_delay(input int max_cycles);
        seed = xorshift32(seed);
        return int'(seed % (max_cycles + 1)); // 0 up to max_cycles
    endfunction

    task automatic check_value(input int id, input string what,
                               input logic [159:0] exp, input logic [159:0] act);
        assert (act === exp) else begin
            $display("Error %s %s: expected %0h, actual %0h", tname[id], what, exp, act);
            errs[id]++;
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic report_test(input int id);
        if (errs[id] == 0) begin
            $display("test %0d %s: ok", id, tname[id]);
        end else begin
            $display("test %0d %s: %0d failing checks", id, tname[id], errs[id]);
        end
    endtask

    // one descriptor per line with src_addr src_size dst_addr dst_size status
    // then end_cnt and abort slot and the profiles after run 1 and after run 2
    task automatic load_stimulus();
        int          fd;
        int          n;
        int          i;
        logic [31:0] w [5];
        n = 0;
        fd = $fopen("magic_seq_stimulus.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open magic_seq_stimulus.txt");
        end else begin
            for (i = 0; i < 4; i++) begin
                n += $fscanf(fd, "%h %h %h %h %h", w[0], w[1], w[2], w[3], w[4]);
                desc_mem[i].src_addr = w[0];
                desc_mem[i].src_size = w[1][seq_pkg::size_w-1:0];
                desc_mem[i].dst_addr = w[2];
                desc_mem[i].dst_size = w[3][seq_pkg::size_w-1:0];
                desc_mem[i].status   = w[4][seq_pkg::stat_w-1:0];
                desc_mem[i].profile  = '0; // host loads a zero count
            end
            n += $fscanf(fd, "%h", w[0]);
            end_val = w[0][seq_pkg::idx_w-1:0];
            n += $fscanf(fd, "%h", w[0]);
            abort_slot = w[0];
            for (i = 0; i < 8; i++) begin
                n += $fscanf(fd, "%h", prof_file[1 + i / 4][i % 4]);
            end
            $fclose(fd);
            if (n != 30) begin
                fail_run("stimulus file is short or malformed");
            end
        end
    endtask

    task automatic wait_reprog();
        int n;
        n = 0;
        @(negedge clk);
        while (!slave_reprog && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!slave_reprog) begin
            fail_run("timeout waiting for slave_reprog");
        end
    endtask

    task automatic wait_state(input seq_pkg::seq_state_e target, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (state != target && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (state != target) begin
            fail_run({"timeout waiting for ", what});
        end
    endtask

    task automatic send_cmd(input seq_pkg::ctrl_cmd_e cmd);
        @(posedge clk);
        ctrl_valid <= 1'b1;
        ctrl_cmd   <= cmd;
        @(posedge clk);
        ctrl_valid <= 1'b0; // one cycle strobe
    endtask

    // host port is still shut out while the fsm waits for the slave reset
    task automatic check_gating();
        @(posedge clk);
        wr_index      <= '0;
        wr_desc       <= ~desc_mem[0];
        wr_sel        <= '1;
        rd_req        <= 1'b1;
        rd_index      <= 2'd1;
        end_cnt_valid <= 1'b1;
        end_cnt_in    <= ~end_val;
        @(negedge clk);
        check_value(2, "wr_ack while running", 0, wr_ack);
        check_value(2, "rd_ready while running", 0, rd_ready);
        @(posedge clk);
        wr_sel        <= '0;
        rd_req        <= 1'b0;
        end_cnt_valid <= 1'b0;
        @(negedge clk);
        check_value(6, "end_cnt after write while running", end_val, end_cnt);
    endtask

    task automatic readback_all(input int row, input int fields_id, input int prof_id);
        seq_pkg::slot_desc_t exp_desc;
        seq_pkg::slot_desc_t got;
        int                  i;
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            rd_req   <= 1'b1;
            rd_index <= i[1:0];
            @(negedge clk);
            got      = rd_desc;
            exp_desc = desc_mem[i];
            check_value(fields_id, "rd_ready", 1, rd_ready);
            check_value(fields_id, "readback fields", exp_desc >> seq_pkg::prof_w,
                        got >> seq_pkg::prof_w); // profile bits dropped
            check_value(prof_id, "readback profile", prof_file[row][i], got.profile);
        end
        @(posedge clk);
        rd_req <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // slave model for one slot from reprogram to exec_fin
    ////////////////////////////////////////////////////////////

    task automatic serve_slot(input int k, input int id, input int abort_step,
                              output bit aborted);
        seq_pkg::slot_desc_t            exp_desc;
        logic [seq_pkg::init_tasks-1:0] pend;
        int                             i;
        aborted = 1'b0;
        repeat (rand_delay(3)) @(posedge clk);
        @(posedge clk);
        nslave_reset <= 1'b0; // slave goes into reset
        repeat (rand_delay(2) + 1) @(posedge clk);
        nslave_reset <= 1'b1;
        wait_state(seq_pkg::st_initializing, "setup chain start");
        i = 0;
        while (i < seq_pkg::init_tasks && !aborted) begin
            pend = init_task;
            check_value(id, "init_task step", 1 << i, pend);
            if (i == abort_step) begin
                send_cmd(seq_pkg::cmd_clear);
                @(negedge clk);
                check_value(id, "state after clear", seq_pkg::st_shutdown, state);
                check_value(id, "slot_cnt after clear", 0, slot_cnt);
                check_value(id, "init_task after clear", 0, init_task);
                aborted = 1'b1;
            end else begin
                repeat (rand_delay(2)) @(posedge clk);
                @(posedge clk);
                init_fin <= pend; // ack the pending task
                @(posedge clk);
                init_fin <= '0;
                @(negedge clk);
                i++;
            end
        end
        if (!aborted) begin
            wait_state(seq_pkg::st_wait4fin, "st_wait4fin");
            exp_desc         = desc_mem[k];
            exp_desc.profile = model_prof[k];
            check_value(id, "init_task in wait4fin", 0, init_task);
            check_value(id, "slave_desc", exp_desc, slave_desc);
            repeat (rand_delay(3)) @(posedge clk);
            @(posedge clk);
            exec_fin <= 1'b1;
            @(posedge clk);
            exec_fin <= 1'b0;
        end
    endtask

    task automatic run_sequence(input int id, input int last, input int abort_step,
                                input bit gate_checks);
        int k;
        bit aborted;
        aborted = 1'b0;
        send_cmd(seq_pkg::cmd_start);
        for (k = 0; k <= last && !aborted; k++) begin
            wait_reprog();
            check_value(id, "slot_cnt at reprog", k, slot_cnt);
            model_prof[k]++; // bumped in the reprog cycle
            if (gate_checks && k == 0) begin
                check_gating();
            end
            serve_slot(k, id, (k == last) ? abort_step : -1, aborted);
        end
        if (!aborted) begin
            wait_state(seq_pkg::st_shutdown, "shutdown after last slot");
            check_value(4, "slot_cnt after run", 0, slot_cnt);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int i;
        int total;
        int failed;
        int sva_fails;
        reset         = 1'b0;
        wr_index      = '0;
        wr_desc       = '0;
        wr_sel        = '0;
        rd_req        = 1'b0;
        rd_index      = '0;
        ctrl_valid    = 1'b0;
        ctrl_cmd      = seq_pkg::cmd_clear;
        end_cnt_valid = 1'b0;
        end_cnt_in    = '0;
        nslave_reset  = 1'b1; // slave out of reset
        init_fin      = '0;
        exec_fin      = 1'b0;
        seed          = 32'haacce0a4;
        tname[1] = "load_readback";
        tname[2] = "gating";
        tname[3] = "sequence_order";
        tname[4] = "completion";
        tname[5] = "abort";
        tname[6] = "end_cnt_guard";
        for (i = 0; i < 4; i++) begin
            errs[i + 1]     = 0;
            model_prof[i]   = 0;
            prof_file[0][i] = '0;
        end
        errs[5] = 0;
        errs[6] = 0;
        load_stimulus();
        repeat (4) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_value(1, "state after reset", seq_pkg::st_shutdown, state);
        check_value(1, "slave_reprog after reset", 0, slave_reprog);
        check_value(1, "rd_ready after reset", 0, rd_ready);
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            wr_index <= i[1:0];
            wr_desc  <= desc_mem[i];
            wr_sel   <= '1; // all six fields
            @(negedge clk);
            check_value(1, "wr_ack", 6'h3f, wr_ack);
        end
        @(posedge clk);
        wr_sel        <= '0;
        end_cnt_valid <= 1'b1;
        end_cnt_in    <= end_val;
        @(posedge clk);
        end_cnt_valid <= 1'b0;
        @(negedge clk);
        check_value(1, "end_cnt", end_val, end_cnt);
        readback_all(0, 1, 1);
        report_test(1);
        run_sequence(3, end_val, -1, 1'b1); // full run with host checks at slot 0
        report_test(3);
        readback_all(1, 2, 4);
        check_value(6, "end_cnt after run", end_val, end_cnt);
        report_test(2);
        report_test(4);
        report_test(6);
        run_sequence(5, abort_slot, 2, 1'b0); // cleared on the third setup task
        readback_all(2, 5, 5);
        report_test(5);
        total  = 0;
        failed = 0;
        for (i = 1; i <= 6; i++) begin
            total += errs[i];
            if (errs[i] != 0) begin
                failed++;
            end
        end
        sva_fails = dut0.fsm0.sva0.fail_cnt; // bound checker in seq_fsm
        $display("tests: 6, failed tests: %0d, failed checks: %0d, failed assertions: %0d",
                 failed, total, sva_fails);
        if (total == 0 && sva_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: magic_seq_core.f
seq_pkg.sv
slot_table.sv
host_access.sv
seq_fsm.sv
magic_seq_core.sv
magic_seq_core_sva.sv
tb_magic_seq_core.sv

// File: magic_seq_stimulus.txt
10000000 0000400 20000000 0000400 1
10010000 0001000 20010000 0001000 2
10020000 03ffff0 20400000 03ffff0 3
1ff00000 0000040 2ff00000 0000040 0
2
1
1 1 1 0
2 2 1 0
